/* reverb_pkg.sv */
package reverb_pkg;

    localparam int SAMPLE_W   = 16;
    localparam int ACC_W      = 48;
    localparam int TAP_COUNT  = 64;
    localparam int BANKS      = 4;
    localparam int LANES      = 2 * BANKS;
    localparam int BANK_DEPTH = TAP_COUNT / BANKS;
    localparam int ADDR_W     = $clog2(BANK_DEPTH);
    localparam int STEPS      = TAP_COUNT / LANES;

    // read 3, write 2, convolve STEPS+4, fold LANES+1
    localparam int CONV_LATENCY = 3 + 2 + (STEPS + 4) + (LANES + 1);

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // lane 2b comes from bank b at the first address, lane 2b+1 at the second
    typedef struct packed {
        sample_t [LANES-1:0] lane;
    } lane_vals_t;

    typedef struct packed {
        logic [ADDR_W-1:0] first_index;
        logic [ADDR_W-1:0] second_index;
    } pair_addr_t;

    typedef enum logic [2:0] {
        WAIT_IMPULSE,
        WAIT_AUDIO,
        READ_HISTORY,
        WRITE_HISTORY,
        CONVOLVING,
        SUMMING
    } conv_state_t;

endpackage

/* dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16
) (
    input  logic                     audio_clk,
    input  logic [$clog2(DEPTH)-1:0] a_addr,
    input  logic                     a_we,
    input  logic [WIDTH-1:0]         a_din,
    input  logic [$clog2(DEPTH)-1:0] b_addr,
    output logic [WIDTH-1:0]         a_dout,
    output logic [WIDTH-1:0]         b_dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    // contents start as silence
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge audio_clk) begin
        if (a_we) begin
            mem[a_addr] <= a_din;
        end
    end

    // read-first: port a returns the old word on a write cycle
    always_ff @(posedge audio_clk) begin
        a_dout <= mem[a_addr];
        b_dout <= mem[b_addr];
    end

endmodule

/* impulse_store.sv */
`timescale 1ns/1ps

module impulse_store import reverb_pkg::*; (
    input  logic                       audio_clk,
    input  logic                       rst_in,
    input  logic                       ir_strobe,
    input  logic signed [SAMPLE_W-1:0] ir_sample,
    input  pair_addr_t                 ir_addr,
    output logic                       impulse_ready,
    output lane_vals_t                 ir_vals
);

    logic [$clog2(TAP_COUNT)-1:0] tap_count;
    logic [$clog2(BANKS)-1:0]     wr_bank;
    logic [ADDR_W-1:0]            wr_addr;
    logic [SAMPLE_W-1:0]          a_dout [BANKS];
    logic [SAMPLE_W-1:0]          b_dout [BANKS];

    // tap t goes to bank t/16 at (16 - t mod 16) mod 16, mirroring the history ring
    assign wr_bank = tap_count[ADDR_W +: $clog2(BANKS)];
    assign wr_addr = '0 - tap_count[ADDR_W-1:0];

    // the counter wraps on the last tap so a reload starts again at tap 0
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            tap_count     <= '0;
            impulse_ready <= 1'b0;
        end else if (ir_strobe) begin
            tap_count     <= tap_count + 1'b1;
            impulse_ready <= (tap_count == TAP_COUNT - 1);
        end
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        logic bank_we;

        assign bank_we = ir_strobe && (wr_bank == b);

        // port a is shared between loading and the first read index
        dual_port_ram #(
            .WIDTH (SAMPLE_W),
            .DEPTH (BANK_DEPTH)
        ) u_ram (
            .audio_clk (audio_clk),
            .a_addr    (bank_we ? wr_addr : ir_addr.first_index),
            .a_we      (bank_we),
            .a_din     (ir_sample),
            .b_addr    (ir_addr.second_index),
            .a_dout    (a_dout[b]),
            .b_dout    (b_dout[b])
        );
    end

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            ir_vals.lane[2*b]   = a_dout[b];
            ir_vals.lane[2*b+1] = b_dout[b];
        end
    end

endmodule

/* audio_history.sv */
`timescale 1ns/1ps

module audio_history import reverb_pkg::*; (
    input  logic                       audio_clk,
    input  logic                       rst_in,
    input  pair_addr_t                 hist_addr,
    input  logic                       hist_shift_we,
    input  logic signed [SAMPLE_W-1:0] hist_sample,
    input  logic                       hist_mode,
    output lane_vals_t                 audio_vals
);

    logic [ADDR_W-1:0]   p;
    logic [ADDR_W-1:0]   base;
    logic                we_q;
    logic [ADDR_W-1:0]   a_addr;
    logic [ADDR_W-1:0]   b_addr;
    logic [SAMPLE_W-1:0] a_dout [BANKS];
    logic [SAMPLE_W-1:0] b_dout [BANKS];
    logic [SAMPLE_W-1:0] shift_q [BANKS-1];
    logic [SAMPLE_W-1:0] din [BANKS];

    // p has already stepped past the newest sample when the reads start
    assign base = p - 1'b1;

    assign a_addr = hist_mode ? base + hist_addr.first_index : p;
    assign b_addr = base + hist_addr.second_index;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            p    <= '0;
            we_q <= 1'b0;
        end else begin
            we_q <= hist_shift_we;
            if (we_q && !hist_shift_we) begin
                p <= p + 1'b1;
            end
        end
    end

    // old words at p, held steady over both write cycles
    always_ff @(posedge audio_clk) begin
        if (!hist_shift_we) begin
            for (int b = 0; b < BANKS - 1; b++) begin
                shift_q[b] <= a_dout[b];
            end
        end
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        if (b == 0) begin : g_head
            assign din[b] = hist_sample;
        end else begin : g_tail
            // oldest word of bank b-1 moves down into bank b
            assign din[b] = shift_q[b-1];
        end

        dual_port_ram #(
            .WIDTH (SAMPLE_W),
            .DEPTH (BANK_DEPTH)
        ) u_ram (
            .audio_clk (audio_clk),
            .a_addr    (a_addr),
            .a_we      (hist_shift_we),
            .a_din     (din[b]),
            .b_addr    (b_addr),
            .a_dout    (a_dout[b]),
            .b_dout    (b_dout[b])
        );
    end

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            audio_vals.lane[2*b]   = a_dout[b];
            audio_vals.lane[2*b+1] = b_dout[b];
        end
    end

endmodule

/* convolve_audio.sv */
`timescale 1ns/1ps

module convolve_audio import reverb_pkg::*; (
    input  logic                       audio_clk,
    input  logic                       rst_in,
    input  logic                       audio_trigger,
    input  logic signed [SAMPLE_W-1:0] audio_in,
    input  logic                       impulse_ready,
    input  logic                       ir_strobe,
    input  lane_vals_t                 ir_vals,
    input  lane_vals_t                 audio_vals,
    output pair_addr_t                 ir_addr,
    output pair_addr_t                 hist_addr,
    output logic                       hist_shift_we,
    output logic signed [SAMPLE_W-1:0] hist_sample,
    output logic                       hist_mode,
    output logic signed [ACC_W-1:0]    convolution_result,
    output logic                       result_valid
);

    conv_state_t                  state;
    logic [$clog2(STEPS + 4)-1:0] phase;
    logic                         accept;
    logic                         mac_en;
    pair_addr_t                   step_q;
    logic signed [2*SAMPLE_W-1:0] prod [LANES];
    logic signed [ACC_W-1:0]      lane_acc [LANES];
    logic signed [ACC_W-1:0]      fold_sum;

    assign accept        = (state == WAIT_AUDIO) && audio_trigger && !ir_strobe;
    assign hist_shift_we = (state == WRITE_HISTORY);
    assign hist_mode     = (state == CONVOLVING);

    // both memories share the layout, so one address pair lines up tap and sample
    assign ir_addr   = step_q;
    assign hist_addr = step_q;

    // address reg, RAM and product reg put three cycles between issue and accumulate
    assign mac_en = (state == CONVOLVING) && (phase >= 3) && (phase <= STEPS + 2);

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state              <= WAIT_IMPULSE;
            phase              <= '0;
            step_q             <= '0;
            result_valid       <= 1'b0;
            convolution_result <= '0;
        end else begin
            result_valid <= 1'b0;
            phase        <= phase + 1'b1;
            case (state)
                WAIT_IMPULSE: begin
                    phase <= '0;
                    if (impulse_ready && !ir_strobe) begin
                        state <= WAIT_AUDIO;
                    end
                end
                WAIT_AUDIO: begin
                    phase <= '0;
                    if (accept) begin
                        state <= READ_HISTORY;
                    end else if (ir_strobe) begin
                        state <= WAIT_IMPULSE;
                    end
                end
                READ_HISTORY: begin
                    if (phase == 2) begin
                        state <= WRITE_HISTORY;
                        phase <= '0;
                    end
                end
                WRITE_HISTORY: begin
                    if (phase == 1) begin
                        state <= CONVOLVING;
                        phase <= '0;
                    end
                end
                CONVOLVING: begin
                    if (phase < STEPS) begin
                        step_q.first_index  <= ADDR_W'(2 * phase);
                        step_q.second_index <= ADDR_W'(2 * phase + 1);
                    end
                    if (phase == STEPS + 3) begin
                        state <= SUMMING;
                        phase <= '0;
                    end
                end
                SUMMING: begin
                    if (phase == LANES) begin
                        convolution_result <= fold_sum;
                        result_valid       <= 1'b1;
                        state              <= WAIT_AUDIO;
                    end
                end
                default: begin
                    state <= WAIT_IMPULSE;
                end
            endcase
        end
    end

    always_ff @(posedge audio_clk) begin
        if (accept) begin
            hist_sample <= audio_in;
        end
        for (int i = 0; i < LANES; i++) begin
            prod[i] <= $signed(ir_vals.lane[i]) * $signed(audio_vals.lane[i]);
            if (accept) begin
                lane_acc[i] <= '0;
            end else if (mac_en) begin
                lane_acc[i] <= lane_acc[i] + prod[i];
            end
        end
        // fold one lane per cycle
        if (state == CONVOLVING) begin
            fold_sum <= '0;
        end else if (state == SUMMING && phase < LANES) begin
            fold_sum <= fold_sum + lane_acc[phase[$clog2(LANES)-1:0]];
        end
    end

    a_valid_pulse: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        result_valid |=> !result_valid
    );

    // valid is registered on the CONV_LATENCY-th edge after the one that took the trigger
    a_latency: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        result_valid |-> $past(accept, CONV_LATENCY + 1)
    );

    a_state_legal: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        state inside {WAIT_IMPULSE, WAIT_AUDIO, READ_HISTORY, WRITE_HISTORY,
                      CONVOLVING, SUMMING}
    );

    // impulse_store writes on any strobe, which would collide with the tap reads
    a_strobe_idle: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        ir_strobe |-> state inside {WAIT_IMPULSE, WAIT_AUDIO}
    );

endmodule

/* convolution_reverb.sv */
`timescale 1ns/1ps

module convolution_reverb import reverb_pkg::*; (
    input  logic                       audio_clk,
    input  logic                       rst_in,
    input  logic                       ir_strobe,
    input  logic signed [SAMPLE_W-1:0] ir_sample,
    input  logic                       audio_trigger,
    input  logic signed [SAMPLE_W-1:0] audio_in,
    output logic                       impulse_ready,
    output logic signed [ACC_W-1:0]    convolution_result,
    output logic                       result_valid
);

    pair_addr_t                 ir_addr;
    pair_addr_t                 hist_addr;
    lane_vals_t                 ir_vals;
    lane_vals_t                 audio_vals;
    logic                       hist_shift_we;
    logic                       hist_mode;
    logic signed [SAMPLE_W-1:0] hist_sample;

    impulse_store u_impulse_store (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .ir_strobe     (ir_strobe),
        .ir_sample     (ir_sample),
        .ir_addr       (ir_addr),
        .impulse_ready (impulse_ready),
        .ir_vals       (ir_vals)
    );

    audio_history u_audio_history (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .hist_addr     (hist_addr),
        .hist_shift_we (hist_shift_we),
        .hist_sample   (hist_sample),
        .hist_mode     (hist_mode),
        .audio_vals    (audio_vals)
    );

    convolve_audio u_convolve_audio (
        .audio_clk          (audio_clk),
        .rst_in             (rst_in),
        .audio_trigger      (audio_trigger),
        .audio_in           (audio_in),
        .impulse_ready      (impulse_ready),
        .ir_strobe          (ir_strobe),
        .ir_vals            (ir_vals),
        .audio_vals         (audio_vals),
        .ir_addr            (ir_addr),
        .hist_addr          (hist_addr),
        .hist_shift_we      (hist_shift_we),
        .hist_sample        (hist_sample),
        .hist_mode          (hist_mode),
        .convolution_result (convolution_result),
        .result_valid       (result_valid)
    );

endmodule

/* reverb_checker.sv */
`timescale 1ns/1ps

module reverb_checker import reverb_pkg::*; (
    input  logic                    audio_clk,
    input  logic                    rst_in,
    input  logic                    ir_strobe,
    input  logic                    impulse_ready,
    input  logic                    result_valid,
    input  logic signed [ACC_W-1:0] convolution_result,
    input  logic                    exp_push,
    input  logic                    exp_check,
    input  logic signed [ACC_W-1:0] exp_value,
    output int                      error_count,
    output int                      pending
);

    logic signed [ACC_W-1:0] exp_q [$];
    logic                    check_q [$];
    int                      cyc_q [$];
    int                      cycle;
    int                      strobes;
    logic                    ready_due;
    logic                    low_due;

    initial begin
        error_count = 0;
        pending     = 0;
        cycle       = 0;
        strobes     = 0;
        ready_due   = 1'b0;
        low_due     = 1'b0;
    end

    always @(posedge audio_clk) begin
        cycle++;
        if (rst_in) begin
            strobes   = 0;
            ready_due = 1'b0;
            low_due   = 1'b0;
        end else begin
            // impulse_ready follows the strobe that completed the load
            if (ready_due && !impulse_ready) begin
                $display("impulse_ready did not rise after the last tap at %0t", $time);
                error_count++;
            end
            if (low_due && impulse_ready) begin
                $display("impulse_ready was high during an incomplete load at %0t", $time);
                error_count++;
            end
            ready_due = ir_strobe && (strobes == TAP_COUNT - 1);
            low_due   = ir_strobe && (strobes != TAP_COUNT - 1);
            if (ir_strobe) begin
                strobes = (strobes + 1) % TAP_COUNT;
            end

            if (exp_push) begin
                exp_q.push_back(exp_value);
                check_q.push_back(exp_check);
                cyc_q.push_back(cycle);
            end

            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    $display("result_valid pulsed with no trigger pending at %0t", $time);
                    error_count++;
                end else begin
                    if (cycle - cyc_q[0] != CONV_LATENCY + 1) begin
                        $display("result came %0d cycles after its trigger instead of %0d",
                                 cycle - cyc_q[0] - 1, CONV_LATENCY);
                        error_count++;
                    end
                    if (check_q[0] && convolution_result !== exp_q[0]) begin
                        $display("Error at %0t: convolution_result expected %h got %h",
                                 $time, exp_q[0], convolution_result);
                        error_count++;
                    end
                    void'(exp_q.pop_front());
                    void'(check_q.pop_front());
                    void'(cyc_q.pop_front());
                end
            end else if (exp_q.size() != 0 && cycle - cyc_q[0] > CONV_LATENCY + 1) begin
                $display("no result arrived for the trigger taken at cycle %0d", cyc_q[0]);
                error_count++;
                void'(exp_q.pop_front());
                void'(check_q.pop_front());
                void'(cyc_q.pop_front());
            end
        end
        pending = exp_q.size();
    end

endmodule

/* tb_convolution_reverb.sv */
`timescale 1ns/1ps

module tb_convolution_reverb import reverb_pkg::*; ();

    localparam int MAX_RECS      = 64;
    localparam int TRIG_SPACING  = 40;
    localparam int KIND_END      = 0;
    localparam int KIND_TAP      = 1;
    localparam int KIND_FILL     = 2;
    localparam int KIND_SAMPLE   = 3;
    localparam int KIND_IDLE     = 4;
    localparam int KIND_REPEAT   = 5;
    localparam int KIND_RUN      = 6;
    localparam int KIND_LOAD     = 7;

    typedef struct packed {
        logic [3:0]       kind;
        logic [3:0]       test;
        logic [15:0]      value;
        logic [ACC_W-1:0] expected;
    } golden_rec_t;

    logic                       audio_clk;
    logic                       rst_in;
    logic                       ir_strobe;
    logic signed [SAMPLE_W-1:0] ir_sample;
    logic                       audio_trigger;
    logic signed [SAMPLE_W-1:0] audio_in;
    logic                       impulse_ready;
    logic signed [ACC_W-1:0]    convolution_result;
    logic                       result_valid;
    logic                       exp_push;
    logic                       exp_check;
    logic signed [ACC_W-1:0]    exp_value;
    int                         error_count;
    int                         pending;

    logic [71:0]          golden_mem [MAX_RECS];
    logic [SAMPLE_W-1:0]  staged [TAP_COUNT];
    golden_rec_t          rec;
    int                   cycle_count;
    int                   cycle_limit;
    int                   tests_run;

    // test 4 data was generated offline from $random with seed 32'h92a7_fcc4

    convolution_reverb DUT (
        .audio_clk          (audio_clk),
        .rst_in             (rst_in),
        .ir_strobe          (ir_strobe),
        .ir_sample          (ir_sample),
        .audio_trigger      (audio_trigger),
        .audio_in           (audio_in),
        .impulse_ready      (impulse_ready),
        .convolution_result (convolution_result),
        .result_valid       (result_valid)
    );

    reverb_checker u_checker (
        .audio_clk          (audio_clk),
        .rst_in             (rst_in),
        .ir_strobe          (ir_strobe),
        .impulse_ready      (impulse_ready),
        .result_valid       (result_valid),
        .convolution_result (convolution_result),
        .exp_push           (exp_push),
        .exp_check          (exp_check),
        .exp_value          (exp_value),
        .error_count        (error_count),
        .pending            (pending)
    );

    initial begin
        audio_clk = 1'b0;
        forever #20 audio_clk = ~audio_clk;
    end

    initial begin
        cycle_count = 0;
        cycle_limit = 0;
        wait (cycle_limit > 0);
        forever begin
            @(posedge audio_clk);
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("simulation timed out after %0d cycles", cycle_count);
                $display("Something failed");
                $finish;
            end
        end
    end

    task automatic step();
        @(posedge audio_clk);
        #2;
    endtask

    task automatic load_staged_taps();
        for (int t = 0; t < TAP_COUNT; t++) begin
            ir_strobe = 1'b1;
            ir_sample = staged[t];
            step();
        end
        ir_strobe = 1'b0;
        for (int t = 0; t < TAP_COUNT; t++) begin
            staged[t] = '0;
        end
        while (!impulse_ready) begin
            step();
        end
        repeat (2) step();
    endtask

    task automatic play_sample(input logic [15:0] value, input logic [ACC_W-1:0] expected,
                               input logic push, input logic check, input logic again);
        audio_trigger = 1'b1;
        audio_in      = value;
        exp_push      = push;
        exp_check     = check;
        exp_value     = expected;
        step();
        audio_trigger = 1'b0;
        exp_push      = 1'b0;
        if (again) begin
            // second trigger lands while the conversion is busy
            repeat (9) step();
            audio_trigger = 1'b1;
            step();
            audio_trigger = 1'b0;
            repeat (TRIG_SPACING - 11) step();
        end else begin
            repeat (TRIG_SPACING - 1) step();
        end
    endtask

    task automatic report_test(input int test, input int errs);
        $display("test %0d: %s (%0d errors)", test, errs == 0 ? "passed" : "FAILED", errs);
    endtask

    initial begin
        int taps;
        int samples;
        int idx;
        int cur_test;
        int err_base;

        rst_in        = 1'b1;
        ir_strobe     = 1'b0;
        ir_sample     = '0;
        audio_trigger = 1'b0;
        audio_in      = '0;
        exp_push      = 1'b0;
        exp_check     = 1'b0;
        exp_value     = '0;
        tests_run     = 0;
        for (int i = 0; i < MAX_RECS; i++) begin
            golden_mem[i] = '0;
        end
        for (int t = 0; t < TAP_COUNT; t++) begin
            staged[t] = '0;
        end
        $readmemh("reverb_golden.mem", golden_mem);

        taps    = 0;
        samples = 0;
        for (int i = 0; i < MAX_RECS; i++) begin
            rec = golden_mem[i];
            if (rec.kind == KIND_LOAD || rec.kind == KIND_FILL) begin
                taps += TAP_COUNT;
            end else if (rec.kind == KIND_RUN) begin
                samples += int'(rec.expected);
            end else if (rec.kind != KIND_END && rec.kind != KIND_TAP) begin
                samples += 1;
            end
        end
        cycle_limit = (taps + TRIG_SPACING * samples) * 3 / 2;

        repeat (5) @(posedge audio_clk);
        #2;
        rst_in = 1'b0;
        step();

        idx      = 0;
        cur_test = 0;
        err_base = 0;
        rec      = golden_mem[0];
        while (rec.kind != KIND_END && idx < MAX_RECS) begin
            if (rec.test != cur_test) begin
                if (cur_test != 0) begin
                    report_test(cur_test, error_count - err_base);
                end
                cur_test = rec.test;
                err_base = error_count;
                tests_run++;
            end
            case (rec.kind)
                KIND_TAP:    staged[rec.expected[5:0]] = rec.value;
                KIND_LOAD:   load_staged_taps();
                KIND_FILL: begin
                    for (int t = 0; t < TAP_COUNT; t++) begin
                        staged[t] = rec.value;
                    end
                    load_staged_taps();
                end
                KIND_SAMPLE: play_sample(rec.value, rec.expected, 1'b1, 1'b1, 1'b0);
                KIND_IDLE:   play_sample(rec.value, rec.expected, 1'b0, 1'b0, 1'b0);
                KIND_REPEAT: play_sample(rec.value, rec.expected, 1'b1, 1'b1, 1'b1);
                KIND_RUN: begin
                    for (int n = 0; n < int'(rec.expected); n++) begin
                        play_sample(rec.value, '0, 1'b1, 1'b0, 1'b0);
                    end
                end
                default: begin
                    $display("golden record %0d has an unknown kind %0d", idx, rec.kind);
                    u_checker.error_count++;
                end
            endcase
            idx++;
            rec = golden_mem[idx];
        end
        if (cur_test != 0) begin
            report_test(cur_test, error_count - err_base);
        end
        repeat (2) step();

        $display("tests run: %0d, errors: %0d, results outstanding: %0d",
                 tests_run, error_count, pending);
        if (error_count == 0 && pending == 0 && tests_run > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* convolution_reverb.f */
reverb_pkg.sv
dual_port_ram.sv
impulse_store.sv
audio_history.sv
convolve_audio.sv
convolution_reverb.sv
reverb_checker.sv
tb_convolution_reverb.sv

/* reverb_golden.mem */
// kind_test_value_expected; kind 1 stage tap (expected = tap index), 2 load all taps with value,
// 3 checked sample, 4 trigger with no result, 5 checked sample plus repeat trigger,
// 6 unchecked run (expected = count), 7 load staged taps, 0 end
4_1_0055_000000000000
1_2_0001_000000000000
7_2_0000_000000000000
3_2_1234_000000001234
3_2_8000_ffffffff8000
3_2_ffff_ffffffffffff
3_2_7fff_000000007fff
3_2_00a5_0000000000a5
1_3_0001_000000000025
7_3_0000_000000000000
6_3_0101_00000000001e
3_3_1111_000000000000
3_3_2222_000000000000
3_3_3333_000000001234
3_3_4444_ffffffff8000
3_3_5555_ffffffffffff
3_3_6666_000000007fff
3_3_7777_0000000000a5
3_3_8888_000000000101
3_3_9999_000000000101
1_4_0003_000000000000
1_4_fffe_000000000001
1_4_0007_000000000005
1_4_ffff_000000000028
7_4_0000_000000000000
3_4_0100_00000003247c
3_4_ff00_00000002c6c9
3_4_1000_000000037540
3_4_0007_fffffffc9acc
3_4_fff0_fffffffd31f0
3_4_0200_000000000c1f
2_5_8000_000000000000
6_5_8000_00000000003f
3_5_8000_001000000000
5_5_8000_001000000000
0_0_0000_000000000000
